//--- filelist.f
+incdir+design
design/apu_pkg.sv
design/apu_alu.sv
design/apu_regfile.sv
design/apu_rep_cnt.sv
design/apu_seq.sv
design/apu_top.sv
test/apu_tb.sv

//--- test/apu_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "apu_defines.svh"

module apu_tb import apu_pkg::*; ();

	localparam int PERIOD      = 20;
	localparam int MAX_REP     = 31;
	localparam int N_CMDS      = 320;		// Upper bound over all tests
	localparam int WATCHDOG_NS = N_CMDS * (MAX_REP + 4) * PERIOD + 5000;

	logic     clk;
	logic     arst_n;
	apu_cmd_t cmd;
	logic     cmd_valid;
	logic     cmd_ready;
	apu_rsp_t rsp;
	logic     rsp_valid;
	logic     rsp_ready;

	logic [`APU_DW-1:0] m_regs [`APU_NREG];	// Model register file
	apu_flags_t         m_flags;
	apu_rsp_t           last_rsp;
	logic [15:0]        lfsr;
	int                 errors;

	apu_top dut_i (
		.clk       (clk),
		.arst_n    (arst_n),
		.cmd       (cmd),
		.cmd_valid (cmd_valid),
		.cmd_ready (cmd_ready),
		.rsp       (rsp),
		.rsp_valid (rsp_valid),
		.rsp_ready (rsp_ready)
	);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// Taps x^16 + x^14 + x^13 + x^11
	function automatic logic [31:0] rand_bits(int n);
		logic [31:0] r;
		logic        fb;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r    = {r[30:0], lfsr[15]};
			fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
			lfsr = {lfsr[14:0], fb};
		end
		return r;
	endfunction

	// Reference ALU on a 64-bit scratch value
	function automatic apu_rsp_t alu_ref(apu_func_e f, apu_size_e sz, logic [31:0] src,
			logic [31:0] arg, logic cin);
		int          w;
		logic [63:0] mask;
		logic [63:0] a;
		logic [63:0] b;
		logic [63:0] ci;
		logic [63:0] t;
		logic [31:0] r;
		logic        cy;
		logic        ov;
		longint      sa;
		longint      sb;
		longint      st;
		longint      lim;
		apu_rsp_t    o;
		w    = 8 * (int'(sz) + 1);
		mask = (64'd1 << w) - 1;
		a    = {32'd0, src} & mask;
		b    = {32'd0, arg} & mask;
		ci   = (f == ADC || f == SBC) ? {63'd0, cin} : 64'd0;
		lim  = longint'(1) << (w - 1);
		sa   = longint'(a) - (a[w-1] ? (longint'(1) << w) : longint'(0));	// Signed view
		sb   = longint'(b) - (b[w-1] ? (longint'(1) << w) : longint'(0));
		st   = 0;
		cy   = 1'b0;
		ov   = 1'b0;
		case (f)
			LD:  t = b;
			AND: t = a & b;
			OR:  t = a | b;
			XOR: t = a ^ b;
			ADD, ADC: begin
				t  = a + b + ci;
				cy = t[w];
				st = sa + sb + longint'(ci);
				ov = (st >= lim) || (st < -lim);
			end
			SUB, SBC: begin
				t  = a - b - ci;	// Bit w is the borrow
				cy = t[w];
				st = sa - sb - longint'(ci);
				ov = (st >= lim) || (st < -lim);
			end
			RL:  t = (a << 1) | {63'd0, a[w-1]};
			RR:  t = (a >> 1) | ({63'd0, a[0]} << (w - 1));
			RLC: t = (a << 1) | {63'd0, cin};
			RRC: t = (a >> 1) | ({63'd0, cin} << (w - 1));
			SRA: t = (a >> 1) | ({63'd0, a[w-1]} << (w - 1));
			SRZ: t = a >> 1;
			MUL: begin
				t  = a * b;
				cy = (t >> w) != 64'd0;
			end
			default: t = '0;
		endcase
		if (f == RL || f == RLC) begin
			cy = a[w-1];
		end else if (f inside {RR, RRC, SRA, SRZ}) begin
			cy = a[0];
		end
		r = t[31:0] & mask[31:0];
		o.data  = r;
		o.flags = '{z: (r == '0), s: r[w-1], c: cy, v: ov};
		return o;
	endfunction

	task automatic compare(logic [63:0] exp, logic [63:0] act, string msg);
		if (exp !== act) begin
			$display("FAIL %0t: %s, expected %0h, got %0h", $time, msg, exp, act);
			errors++;
		end
	endtask

	// Starts and ends 2 ns after a rising edge
	task automatic run_cmd(apu_func_e f, apu_size_e sz, int rd, int rs, logic use_imm,
			logic [7:0] argv, int rep, int hold);
		apu_cmd_t    c;
		apu_rsp_t    exp;
		apu_rsp_t    got;
		logic [31:0] srcv;
		logic [31:0] argval;
		logic        ready_seen;
		int          lat;
		int          tries;
		string       tag;
		c.func    = f;
		c.sz      = sz;
		c.rd      = 3'(rd);
		c.rs      = 3'(rs);
		c.arg_imm = use_imm;
		c.arg.imm = argv;
		c.rep     = 5'(rep);
		tag = $sformatf("%s %s rd%0d rep %0d", f.name(), sz.name(), rd, rep);
		for (int p = 0; p <= rep; p++) begin
			srcv   = (p == 0) ? m_regs[rs] : m_regs[rd];	// Later passes reuse rd
			argval = use_imm ? {24'd0, argv} : m_regs[argv[2:0]];
			exp    = alu_ref(f, sz, srcv, argval, m_flags.c);
			m_regs[rd] = exp.data;
			m_flags    = exp.flags;
		end
		cmd        = c;
		cmd_valid  = 1'b1;
		ready_seen = 1'b0;
		tries      = 0;
		while (!ready_seen) begin
			@(negedge clk);
			ready_seen = cmd_ready;
			@(posedge clk);
			#2;
			tries++;
			if (!ready_seen && tries > 50) begin
				$display("ERROR: %s was never accepted by the DUT", tag);
				errors++;
				cmd_valid = 1'b0;
				return;
			end
		end
		cmd_valid = 1'b0;
		lat = 0;
		@(negedge clk);
		while (!rsp_valid) begin
			compare(0, cmd_ready, {tag, " cmd_ready during passes"});
			@(posedge clk);
			#2;
			lat++;
			if (lat > MAX_REP + 8) begin
				$display("ERROR: no response arrived for %s", tag);
				errors++;
				return;
			end
			@(negedge clk);
		end
		compare(rep + 1, lat, {tag, " latency"});
		got = rsp;
		for (int i = 0; i < hold; i++) begin
			@(posedge clk);
			#2;
			@(negedge clk);
			compare(got, rsp, {tag, " rsp held"});
			compare(0, cmd_ready, {tag, " cmd_ready while held"});
		end
		@(posedge clk);
		#2;
		rsp_ready = 1'b1;
		@(negedge clk);
		compare(0, cmd_ready, {tag, " cmd_ready before take"});
		@(posedge clk);
		#2;
		rsp_ready = 1'b0;
		compare(0, rsp_valid, {tag, " rsp_valid after take"});
		compare(1, cmd_ready, {tag, " cmd_ready after take"});
		compare(exp.data, got.data, {tag, " data"});
		compare(exp.flags, got.flags, {tag, " flags"});
		last_rsp = got;
	endtask

	// Build a 32-bit value from bytes with LD, RL by 8 and OR
	task automatic load_value(int rd, logic [31:0] v);
		run_cmd(LD, S32, rd, 0, 1'b1, v[31:24], 0, 0);
		for (int i = 2; i >= 0; i--) begin
			run_cmd(RL, S32, rd, rd, 1'b1, 8'h00, 7, 0);
			run_cmd(OR, S32, rd, rd, 1'b1, v[i*8 +: 8], 0, 0);
		end
	endtask

	task automatic logic_test();
		for (int s = 0; s < 4; s++) begin
			run_cmd(LD, apu_size_e'(s), 1, 0, 1'b1, 8'h80 ^ 8'(s), 0, 0);
		end
		run_cmd(LD, S8, 2, 0, 1'b1, 8'h00, 0, 0);		// Z set
		load_value(1, rand_bits(32));
		load_value(2, rand_bits(32));
		run_cmd(AND, S32, 3, 1, 1'b0, 8'd2, 0, 0);
		run_cmd(OR, S16, 3, 1, 1'b0, 8'd2, 0, 0);
		run_cmd(XOR, S24, 3, 1, 1'b0, 8'd2, 0, 0);
		run_cmd(XOR, S32, 4, 1, 1'b0, 8'd1, 0, 0);
		run_cmd(NUL, S32, 4, 1, 1'b0, 8'd2, 0, 0);
	endtask

	task automatic arith_test();
		for (int s = 0; s < 4; s++) begin
			load_value(1, rand_bits(32));
			load_value(2, rand_bits(32));
			run_cmd(ADD, apu_size_e'(s), 3, 1, 1'b0, 8'd2, 0, 0);
			run_cmd(ADC, apu_size_e'(s), 4, 1, 1'b0, 8'd2, 0, 0);	// Carry of ADD
			run_cmd(SUB, apu_size_e'(s), 5, 1, 1'b0, 8'd2, 0, 0);
			run_cmd(SBC, apu_size_e'(s), 6, 1, 1'b0, 8'd2, 0, 0);
		end
	endtask

	task automatic shift_test();
		for (int f = RL; f <= SRZ; f++) begin
			load_value(6, rand_bits(32));
			for (int r = 0; r < 8; r++) begin
				run_cmd(apu_func_e'(f), apu_size_e'(r % 4), 7, 6, 1'b1, 8'h00, r, 0);
			end
		end
	endtask

	task automatic mul_test();
		load_value(1, 32'hffff_ffff);
		run_cmd(LD, S32, 3, 0, 1'b1, 8'h0f, 0, 0);
		for (int s = 0; s < 4; s++) begin
			run_cmd(MUL, apu_size_e'(s), 2, 1, 1'b1, 8'h02, 0, 0);
			compare(1, last_rsp.flags.c, "MUL carry on wide product");
			run_cmd(MUL, apu_size_e'(s), 4, 3, 1'b1, 8'h0f, 0, 0);
			compare(0, last_rsp.flags.c, "MUL carry on product that fits");
		end
		load_value(5, rand_bits(32));
		for (int s = 0; s < 4; s++) begin
			run_cmd(MUL, apu_size_e'(s), 6, 5, 1'b0, 8'd5, 0, 0);
		end
	endtask

	task automatic zs_check(logic [31:0] v);
		logic [63:0] mask;
		load_value(1, v);
		for (int s = 0; s < 4; s++) begin
			mask = (64'd1 << (8 * (s + 1))) - 1;
			run_cmd(XOR, apu_size_e'(s), 2, 1, 1'b1, 8'h00, 0, 0);
			compare(0, last_rsp.data & ~mask[31:0], "bits above operand size");
		end
	endtask

	task automatic backpressure_test();
		run_cmd(LD, S8, 1, 0, 1'b1, 8'h81, 0, 0);
		run_cmd(RL, S8, 1, 1, 1'b1, 8'h00, 5, 6);		// Six cycles held off
		run_cmd(SRZ, S16, 2, 1, 1'b1, 8'h00, 2, 3);
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("ERROR: watchdog expired before the tests finished");
		$display("Simulation failed");
		$finish;
	end

	initial begin
		cmd       = '0;
		cmd_valid = 1'b0;
		rsp_ready = 1'b0;
		arst_n    = 1'b0;
		lfsr      = 16'd69;
		errors    = 0;
		m_flags   = '0;
		last_rsp  = '0;
		for (int i = 0; i < `APU_NREG; i++) begin
			m_regs[i] = '0;
		end
		repeat (2) @(posedge clk);
		#2;
		arst_n = 1'b1;
		compare(1, cmd_ready, "cmd_ready after reset");
		compare(0, rsp_valid, "rsp_valid after reset");
		logic_test();
		arith_test();
		shift_test();
		mul_test();
		zs_check(32'h1234_5600);
		zs_check(32'hffff_0080);
		zs_check(32'hab80_0000);
		backpressure_test();
		$display("Tests done with %0d errors", errors);
		if (errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- design/apu_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "apu_defines.svh"

module apu_top import apu_pkg::*; (
	input  logic     clk,
	input  logic     arst_n,
	input  apu_cmd_t cmd,
	input  logic     cmd_valid,
	output logic     cmd_ready,
	output apu_rsp_t rsp,
	output logic     rsp_valid,
	input  logic     rsp_ready
);

	logic [`APU_RW-1:0] rf_ra;
	logic [`APU_RW-1:0] rf_rb;
	logic [`APU_RW-1:0] rf_wa;
	logic               rf_we;
	logic               flags_we;
	logic [`APU_DW-1:0] src;
	logic [`APU_DW-1:0] arg_reg;
	logic [`APU_DW-1:0] arg;
	apu_flags_t         flags_q;		// Stored flags, carry goes to ALU
	apu_func_e          alu_func;
	apu_size_e          alu_sz;
	logic [`APU_DW-1:0] alu_res;
	apu_flags_t         alu_flags;
	logic               cnt_load;
	logic               cnt_step;
	logic               cnt_last;

	apu_seq seq_i (
		.clk       (clk),
		.arst_n    (arst_n),
		.cmd       (cmd),
		.cmd_valid (cmd_valid),
		.cmd_ready (cmd_ready),
		.rsp       (rsp),
		.rsp_valid (rsp_valid),
		.rsp_ready (rsp_ready),
		.rf_ra     (rf_ra),
		.rf_rb     (rf_rb),
		.rf_wa     (rf_wa),
		.rf_we     (rf_we),
		.flags_we  (flags_we),
		.arg_reg   (arg_reg),
		.arg       (arg),
		.alu_func  (alu_func),
		.alu_sz    (alu_sz),
		.alu_res   (alu_res),
		.alu_flags (alu_flags),
		.cnt_load  (cnt_load),
		.cnt_step  (cnt_step),
		.cnt_last  (cnt_last)
	);

	apu_rep_cnt cnt_i (
		.clk    (clk),
		.arst_n (arst_n),
		.load   (cnt_load),
		.rep    (cmd.rep),
		.step   (cnt_step),
		.last   (cnt_last)
	);

	apu_regfile rf_i (
		.clk      (clk),
		.arst_n   (arst_n),
		.ra       (rf_ra),
		.rb       (rf_rb),
		.wa       (rf_wa),
		.we       (rf_we),
		.wd       (alu_res),
		.flags_we (flags_we),
		.flags_in (alu_flags),
		.rdata_a  (src),
		.rdata_b  (arg_reg),
		.flags    (flags_q)
	);

	apu_alu alu_i (
		.src   (src),
		.arg   (arg),
		.c     (flags_q.c),
		.func  (alu_func),
		.sz    (alu_sz),
		.dst   (alu_res),
		.flags (alu_flags)
	);

endmodule

`default_nettype wire

//--- design/apu_seq.sv
`timescale 1ns/1ps
`default_nettype none

`include "apu_defines.svh"

module apu_seq import apu_pkg::*; (
	input  logic               clk,
	input  logic               arst_n,
	input  apu_cmd_t           cmd,
	input  logic               cmd_valid,
	output logic               cmd_ready,
	output apu_rsp_t           rsp,
	output logic               rsp_valid,
	input  logic               rsp_ready,
	output logic [`APU_RW-1:0] rf_ra,
	output logic [`APU_RW-1:0] rf_rb,
	output logic [`APU_RW-1:0] rf_wa,
	output logic               rf_we,
	output logic               flags_we,
	input  logic [`APU_DW-1:0] arg_reg,
	output logic [`APU_DW-1:0] arg,
	output apu_func_e          alu_func,
	output apu_size_e          alu_sz,
	input  logic [`APU_DW-1:0] alu_res,
	input  apu_flags_t         alu_flags,
	output logic               cnt_load,
	output logic               cnt_step,
	input  logic               cnt_last
);

	typedef enum logic [1:0] {IDLE, EXEC, RESP} state_e;

	state_e   state;
	apu_cmd_t cmd_q;
	apu_rsp_t rsp_q;
	logic     first;
	logic     accept;
	logic     pass;

	assign cmd_ready = (state == IDLE);
	assign accept    = cmd_valid && cmd_ready;
	assign pass      = (state == EXEC);		// One pass per cycle

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= IDLE;
			first <= 1'b0;
		end else begin
			case (state)
				IDLE:    if (accept) state <= EXEC;
				EXEC:    if (cnt_last) state <= RESP;
				RESP:    if (rsp_ready) state <= IDLE;
				default: state <= IDLE;
			endcase
			if (accept) begin
				first <= 1'b1;
			end else if (pass) begin
				first <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			cmd_q <= cmd;
		end
		if (pass && cnt_last) begin
			rsp_q <= '{data: alu_res, flags: alu_flags};
		end
	end

	// Later passes feed the result back in as source
	assign rf_ra    = first ? cmd_q.rs : cmd_q.rd;
	assign rf_rb    = cmd_q.arg.rg.idx;
	assign rf_wa    = cmd_q.rd;
	assign rf_we    = pass;
	assign flags_we = pass;

	assign arg = cmd_q.arg_imm ? {{(`APU_DW-8){1'b0}}, cmd_q.arg.imm} : arg_reg;

	assign alu_func = cmd_q.func;
	assign alu_sz   = cmd_q.sz;

	assign cnt_load = accept;
	assign cnt_step = pass;

	assign rsp       = rsp_q;
	assign rsp_valid = (state == RESP);

endmodule

`default_nettype wire

//--- design/apu_rep_cnt.sv
`timescale 1ns/1ps
`default_nettype none

`include "apu_defines.svh"

module apu_rep_cnt (
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic                 load,
	input  logic [`APU_REPW-1:0] rep,
	input  logic                 step,
	output logic                 last
);

	logic [`APU_REPW-1:0] cnt;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cnt <= '0;
		end else if (load) begin
			cnt <= rep;
		end else if (step && !last) begin
			cnt <= cnt - 1'b1;
		end
	end

	assign last = (cnt == '0);		// Zero left means final pass

endmodule

`default_nettype wire

//--- design/apu_regfile.sv
`timescale 1ns/1ps
`default_nettype none

`include "apu_defines.svh"

module apu_regfile import apu_pkg::*; (
	input  logic               clk,
	input  logic               arst_n,
	input  logic [`APU_RW-1:0] ra,
	input  logic [`APU_RW-1:0] rb,
	input  logic [`APU_RW-1:0] wa,
	input  logic               we,
	input  logic [`APU_DW-1:0] wd,
	input  logic               flags_we,
	input  apu_flags_t         flags_in,
	output logic [`APU_DW-1:0] rdata_a,
	output logic [`APU_DW-1:0] rdata_b,
	output apu_flags_t         flags
);

	logic [`APU_DW-1:0] regs [`APU_NREG];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < `APU_NREG; i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			regs[wa] <= wd;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			flags <= '0;
		end else if (flags_we) begin
			flags <= flags_in;
		end
	end

	assign rdata_a = regs[ra];
	assign rdata_b = regs[rb];

endmodule

`default_nettype wire

//--- design/apu_alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "apu_defines.svh"

module apu_alu import apu_pkg::*; (
	input  logic [`APU_DW-1:0] src,
	input  logic [`APU_DW-1:0] arg,
	input  logic               c,
	input  apu_func_e          func,
	input  apu_size_e          sz,
	output logic [`APU_DW-1:0] dst,
	output apu_flags_t         flags
);

	logic [`APU_DW-1:0]   mask;
	logic [4:0]           msb;
	logic [`APU_DW-1:0]   topb;
	logic [`APU_DW-1:0]   a;
	logic [`APU_DW-1:0]   b;
	logic                 cin;
	logic [`APU_DW:0]     sum;
	logic [`APU_DW:0]     diff;
	logic [2*`APU_DW-1:0] prod;
	logic [`APU_DW-1:0]   res;
	logic                 cy;
	logic                 ov;

	assign msb  = {sz, 3'b111};		// 7, 15, 23 or 31
	assign topb = {{(`APU_DW-1){1'b0}}, 1'b1} << msb;

	always_comb begin
		case (sz)
			S8:      mask = 32'h0000_00ff;
			S16:     mask = 32'h0000_ffff;
			S24:     mask = 32'h00ff_ffff;
			default: mask = 32'hffff_ffff;
		endcase
	end

	assign a = src & mask;
	assign b = arg & mask;

	assign cin  = (func == ADC || func == SBC) ? c : 1'b0;
	assign sum  = {1'b0, a} + {1'b0, b} + cin;
	assign diff = {1'b0, a} - {1'b0, b} - cin;	// Borrow lands above msb
	assign prod = a * b;

	always_comb begin
		res = '0;
		cy  = 1'b0;
		ov  = 1'b0;
		case (func)
			LD:  res = b;
			AND: res = a & b;
			OR:  res = a | b;
			XOR: res = a ^ b;
			ADD, ADC: begin
				res = sum[`APU_DW-1:0] & mask;
				cy  = sum[msb + 1];
				ov  = (a[msb] == b[msb]) && (res[msb] != a[msb]);
			end
			SUB, SBC: begin
				res = diff[`APU_DW-1:0] & mask;
				cy  = diff[msb + 1];
				ov  = (a[msb] != b[msb]) && (res[msb] != a[msb]);
			end
			RL: begin
				res = ((a << 1) | a[msb]) & mask;
				cy  = a[msb];
			end
			RR: begin
				res = (a >> 1) | ({`APU_DW{a[0]}} & topb);
				cy  = a[0];
			end
			RLC: begin
				res = ((a << 1) | c) & mask;		// Carry enters at bit 0
				cy  = a[msb];
			end
			RRC: begin
				res = (a >> 1) | ({`APU_DW{c}} & topb);
				cy  = a[0];
			end
			SRA: begin
				res = (a >> 1) | ({`APU_DW{a[msb]}} & topb);	// Sign kept
				cy  = a[0];
			end
			SRZ: begin
				res = a >> 1;
				cy  = a[0];
			end
			MUL: begin
				res = prod[`APU_DW-1:0] & mask;
				cy  = |(prod & ~{{`APU_DW{1'b0}}, mask});	// Product too wide
			end
			default: res = '0;		// NUL
		endcase
	end

	assign dst   = res;
	assign flags = '{z: (res == '0), s: res[msb], c: cy, v: ov};

endmodule

`default_nettype wire

//--- design/apu_pkg.sv
`default_nettype none

`include "apu_defines.svh"

package apu_pkg;

	typedef enum logic [3:0] {
		LD, AND, OR, XOR,		// 0..3
		ADD, SUB, ADC, SBC,		// 4..7
		RL, RR, RLC, RRC,		// 8..11
		SRA, SRZ, NUL, MUL		// 12..15
	} apu_func_e;

	typedef enum logic [1:0] {
		S8,
		S16,
		S24,
		S32
	} apu_size_e;

	// Second operand field, read as immediate or as register index
	typedef union packed {
		logic [7:0] imm;
		struct packed {
			logic [4:0]         pad;
			logic [`APU_RW-1:0] idx;
		} rg;
	} apu_arg_u;

	typedef struct packed {
		apu_func_e            func;
		apu_size_e            sz;
		logic [`APU_RW-1:0]   rd;
		logic [`APU_RW-1:0]   rs;
		logic                 arg_imm;	// Select imm view of arg
		apu_arg_u             arg;
		logic [`APU_REPW-1:0] rep;		// Extra passes after the first
	} apu_cmd_t;

	typedef struct packed {
		logic z;
		logic s;
		logic c;
		logic v;
	} apu_flags_t;

	typedef struct packed {
		logic [`APU_DW-1:0] data;
		apu_flags_t         flags;
	} apu_rsp_t;

endpackage

`default_nettype wire

//--- design/apu_defines.svh
`ifndef APU_DEFINES_SVH
`define APU_DEFINES_SVH

// Datapath width
`define APU_DW 32

// Register file depth and index width
`define APU_NREG 8
`define APU_RW 3

// Repeat count field, up to 31 extra passes
`define APU_REPW 5

`endif
